// File: src.f
+incdir+hw
hw/rob_pkg.sv
hw/insn_decode.sv
hw/rob_livetarget.sv
hw/rob_buffer.sv
hw/reg_status.sv
hw/rob_top.sv
dv/rob_checker.sv
dv/tb_top.sv

// File: run.sh
#!/bin/sh
# Builds the reorder buffer testbench with Verilator and runs it once

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f src.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_top)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

# The run passes only if the testbench printed its pass line
if echo "$out" | grep -qx 'PASS: all tests'; then
	exit 0
fi
exit 1

// File: dv/tb_top.sv
`timescale 1ns/1ps
`include "rob_params.svh"

module tb_top;

	logic clk;
	logic reset;
	logic disp_valid;
	rob_pkg::insn_u disp_insn;
	logic [`TAG_W-1:0] disp_tag;
	rob_pkg::credit_t credit;
	logic cmp_valid;
	logic [`TAG_W-1:0] cmp_tag;
	logic miss_valid;
	logic [`TAG_W-1:0] miss_tag;
	rob_pkg::commit_t commit;
	logic [`REG_W-1:0] qry_reg;
	rob_pkg::status_t qry_status;
	int errors;
	int fails;
	int seed;
	int credits;
	// Sender side view of the buffer with one flag set per tag
	logic [`TAG_W-1:0] t_tail;
	logic pend [`ROB_ENTRIES];
	logic cmp_sent [`ROB_ENTRIES];
	logic is_br [`ROB_ENTRIES];
	logic miss_sent;

	rob_top uut (
		.clk        (clk),
		.reset      (reset),
		.disp_valid (disp_valid),
		.disp_insn  (disp_insn),
		.disp_tag   (disp_tag),
		.credit     (credit),
		.cmp_valid  (cmp_valid),
		.cmp_tag    (cmp_tag),
		.miss_valid (miss_valid),
		.miss_tag   (miss_tag),
		.commit     (commit),
		.qry_reg    (qry_reg),
		.qry_status (qry_status)
	);

	rob_checker u_check (
		.clk        (clk),
		.reset      (reset),
		.disp_valid (disp_valid),
		.disp_insn  (disp_insn),
		.disp_tag   (disp_tag),
		.credit     (credit),
		.cmp_valid  (cmp_valid),
		.cmp_tag    (cmp_tag),
		.miss_valid (miss_valid),
		.miss_tag   (miss_tag),
		.commit     (commit),
		.qry_reg    (qry_reg),
		.qry_status (qry_status),
		.errors     (errors)
	);

	always #5 clk = ~clk;

	function automatic int outstanding();
		int n;
		n = 0;
		for (int k = 0; k < `ROB_ENTRIES; k++)
			n += int'(pend[k]);
		return n;
	endfunction

	// ==================================================
	// One clock of stimulus
	// ==================================================

	// Mode 0 idles and mode 1 only completes, while mode 2 also dispatches and mispredicts
	task automatic drive_cycle(input int mode, input logic [`REG_W-1:0] qry);
		int start;
		logic [`TAG_W-1:0] tg;
		logic [`TAG_W-1:0] nstomp;
		logic [`INSN_W-1:0] word;
		logic picked;
		@(posedge clk);
		// Book the cycle that just ended because credits come back one edge late
		credits = credits + int'(credit.count);
		if (commit.valid)
			pend[commit.tag] = 1'b0;
		if (miss_valid) begin
			nstomp = t_tail - miss_tag - 1'b1;
			for (int k = 1; k <= int'(nstomp); k++)
				pend[miss_tag + `TAG_W'(k)] = 1'b0;
			t_tail = miss_tag + 1'b1;
		end
		if (disp_valid) begin
			credits = credits - 1;
			pend[t_tail] = 1'b1;
			cmp_sent[t_tail] = 1'b0;
			is_br[t_tail] = disp_insn.b.kind;
			t_tail = t_tail + 1'b1;
		end
		if (credits + outstanding() != `ROB_ENTRIES) begin
			fails++;
			$display("ERR @%0t: %0d credits held with %0d entries outstanding",
				$time, credits, outstanding());
		end
		disp_valid <= 1'b0;
		cmp_valid <= 1'b0;
		miss_valid <= 1'b0;
		qry_reg <= qry;
		picked = 1'b0;
		// Mispredict some in-flight branch now and then
		if (mode == 2 && ($random(seed) & 15) == 0) begin
			start = $random(seed);
			for (int k = 0; k < `ROB_ENTRIES; k++) begin
				tg = `TAG_W'(start + k);
				if (!picked && pend[tg] && is_br[tg]) begin
					picked = 1'b1;
					miss_valid <= 1'b1;
					miss_tag <= tg;
				end
			end
		end
		miss_sent = picked;
		if (mode == 2 && !miss_sent && credits > 0 && ($random(seed) & 1) != 0) begin
			word = 16'($random(seed));
			// Roughly one word in four is a branch
			word[`INSN_W-1] = (($random(seed) & 3) == 0);
			disp_valid <= 1'b1;
			disp_insn <= word;
		end
		if (mode != 0 && !miss_sent && ($random(seed) & 3) != 0) begin
			start = $random(seed);
			picked = 1'b0;
			for (int k = 0; k < `ROB_ENTRIES; k++) begin
				tg = `TAG_W'(start + k);
				if (!picked && pend[tg] && !cmp_sent[tg]) begin
					picked = 1'b1;
					cmp_sent[tg] = 1'b1;
					cmp_valid <= 1'b1;
					cmp_tag <= tg;
				end
			end
		end
	endtask

	initial begin
		int sweep;
		int waited;
		seed = 75018;
		clk = 1'b0;
		reset = 1'b1;
		disp_valid = 1'b0;
		disp_insn = '0;
		cmp_valid = 1'b0;
		cmp_tag = '0;
		miss_valid = 1'b0;
		miss_tag = '0;
		qry_reg = '0;
		credits = `ROB_ENTRIES;
		t_tail = '0;
		for (int k = 0; k < `ROB_ENTRIES; k++) begin
			pend[k] = 1'b0;
			cmp_sent[k] = 1'b0;
			is_br[k] = 1'b0;
		end
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		sweep = 0;
		for (int cyc = 0; cyc < 4000; cyc++) begin
			if (sweep > 0) begin
				// Read back every register of the rebuilt table while nothing new is sent
				drive_cycle(0, `REG_W'(`NREGS - sweep));
				sweep--;
			end else begin
				drive_cycle(2, `REG_W'($random(seed)));
				if (miss_sent)
					sweep = `NREGS;
			end
		end
		// ==================================================
		// Drain everything still in flight
		// ==================================================
		drive_cycle(1, '0);
		waited = 0;
		while (outstanding() > 0 && waited < 300) begin
			drive_cycle(1, `REG_W'($random(seed)));
			waited++;
		end
		if (outstanding() > 0) begin
			fails++;
			$display("Timeout: %0d entries never committed during drain", outstanding());
		end
		repeat (2) drive_cycle(0, '0);
		$display("Run complete: %0d checker errors, %0d testbench failures", errors, fails);
		if (errors == 0 && fails == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	// Guard against a run that stops making progress
	initial begin
		#200000;
		$display("Timeout: simulation did not finish within 200 us");
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

// File: dv/rob_checker.sv
`timescale 1ns/1ps
`include "rob_params.svh"

// Reference model of the reorder buffer and the register status table,
// built from the port traffic and compared with the DUT at every edge
module rob_checker (
	input  logic               clk,
	input  logic               reset,
	input  logic               disp_valid,
	input  logic [`INSN_W-1:0] disp_insn,
	input  logic [`TAG_W-1:0]  disp_tag,
	input  rob_pkg::credit_t   credit,
	input  logic               cmp_valid,
	input  logic [`TAG_W-1:0]  cmp_tag,
	input  logic               miss_valid,
	input  logic [`TAG_W-1:0]  miss_tag,
	input  rob_pkg::commit_t   commit,
	input  logic [`REG_W-1:0]  qry_reg,
	input  rob_pkg::status_t   qry_status,
	output int                 errors
);

	logic m_valid [`ROB_ENTRIES];
	logic m_done [`ROB_ENTRIES];
	logic [`REG_W-1:0] m_t1 [`ROB_ENTRIES];
	logic [`REG_W-1:0] m_t2 [`ROB_ENTRIES];
	logic [`TAG_W-1:0] m_head;
	logic [`TAG_W-1:0] m_tail;
	logic m_ready [`NREGS];
	logic [`TAG_W-1:0] m_src [`NREGS];
	// The head is valid and done, so it leaves in this cycle
	logic retire;

	task automatic flag_mismatch(input string msg);
		errors++;
		$display("ERR @%0t: %s", $time, msg);
	endtask

	function automatic logic writes(input logic [`TAG_W-1:0] tg, input int r);
		return m_valid[tg] && (int'(m_t1[tg]) == r || int'(m_t2[tg]) == r);
	endfunction

	// ==================================================
	// Compare outputs with the model before the edge
	// ==================================================

	task automatic compare_outputs();
		logic [`TAG_W-1:0] miss_age;
		int freed;
		freed = int'(retire);
		if (disp_valid && disp_tag != m_tail)
			flag_mismatch($sformatf("disp_tag %0d, model tail %0d", disp_tag, m_tail));
		if (disp_valid && m_valid[m_tail])
			flag_mismatch($sformatf("dispatch into occupied entry %0d", m_tail));
		if (commit.valid != retire)
			flag_mismatch($sformatf("commit valid %0b, expected %0b", commit.valid, retire));
		else if (retire && (commit.tag != m_head || commit.tgt1 != m_t1[m_head]
				|| commit.tgt2 != m_t2[m_head]))
			flag_mismatch($sformatf("commit tag %0d regs %0d %0d, expected %0d regs %0d %0d",
				commit.tag, commit.tgt1, commit.tgt2, m_head, m_t1[m_head], m_t2[m_head]));
		// Every valid entry behind the branch comes back as a credit
		if (miss_valid) begin
			miss_age = miss_tag - m_head;
			for (int a = int'(miss_age) + 1; a < `ROB_ENTRIES; a++)
				freed += int'(m_valid[m_head + `TAG_W'(a)]);
		end
		if (int'(credit.count) != freed)
			flag_mismatch($sformatf("credit %0d, expected %0d", credit.count, freed));
		// A ready register has no producer worth comparing
		if (qry_status.ready != m_ready[qry_reg]
				|| (!m_ready[qry_reg] && qry_status.tag != m_src[qry_reg]))
			flag_mismatch($sformatf("r%0d ready %0b tag %0d, expected ready %0b tag %0d",
				qry_reg, qry_status.ready, qry_status.tag, m_ready[qry_reg], m_src[qry_reg]));
	endtask

	// ==================================================
	// Model update at the edge
	// ==================================================

	task automatic advance_model();
		logic [`TAG_W-1:0] miss_age;
		logic [`TAG_W-1:0] tg;
		logic [`REG_W-1:0] t1;
		logic [`REG_W-1:0] t2;
		logic found;
		if (miss_valid) begin
			miss_age = miss_tag - m_head;
			// Scan from the branch toward the head, the first hit is the youngest writer
			for (int r = 1; r < `NREGS; r++) begin
				found = 1'b0;
				for (int a = int'(miss_age); a >= 0; a--) begin
					tg = m_head + `TAG_W'(a);
					// A head that retires in the same cycle owns nothing any more
					if (!found && !(retire && a == 0) && writes(tg, r)) begin
						found = 1'b1;
						m_src[r] = tg;
					end
				end
				m_ready[r] = !found;
			end
			for (int a = int'(miss_age) + 1; a < `ROB_ENTRIES; a++)
				m_valid[m_head + `TAG_W'(a)] = 1'b0;
			m_tail = miss_tag + 1'b1;
		end else if (retire) begin
			for (int r = 1; r < `NREGS; r++) begin
				if (writes(m_head, r) && m_src[r] == m_head)
					m_ready[r] = 1'b1;
			end
		end
		if (retire) begin
			m_valid[m_head] = 1'b0;
			m_head = m_head + 1'b1;
		end
		if (cmp_valid)
			m_done[cmp_tag] = 1'b1;
		// Dispatch comes last so it overrides a commit of the same register
		if (disp_valid) begin
			t1 = disp_insn[`INSN_W-1] ? '0 : disp_insn[`INSN_W-2 -: `REG_W];
			t2 = disp_insn[`INSN_W-1] ? '0 : disp_insn[`INSN_W-2-`REG_W -: `REG_W];
			m_valid[m_tail] = 1'b1;
			m_done[m_tail] = 1'b0;
			m_t1[m_tail] = t1;
			m_t2[m_tail] = t2;
			for (int r = 1; r < `NREGS; r++) begin
				if (int'(t1) == r || int'(t2) == r) begin
					m_ready[r] = 1'b0;
					m_src[r] = m_tail;
				end
			end
			m_tail = m_tail + 1'b1;
		end
	endtask

	always @(posedge clk) begin
		if (reset) begin
			m_head = '0;
			m_tail = '0;
			for (int n = 0; n < `ROB_ENTRIES; n++) begin
				m_valid[n] = 1'b0;
				m_done[n] = 1'b0;
			end
			for (int r = 0; r < `NREGS; r++) begin
				m_ready[r] = 1'b1;
				m_src[r] = '0;
			end
		end else begin
			retire = m_valid[m_head] && m_done[m_head];
			compare_outputs();
			advance_model();
		end
	end

endmodule

// File: hw/rob_top.sv
`timescale 1ns/1ps
`include "rob_params.svh"

// Rename-recovery core: decode, reorder buffer, live targets, status table
module rob_top (
	input  logic              clk,
	input  logic              reset,
	input  logic              disp_valid,
	input  rob_pkg::insn_u    disp_insn,
	output logic [`TAG_W-1:0] disp_tag,
	output rob_pkg::credit_t  credit,
	input  logic              cmp_valid,
	input  logic [`TAG_W-1:0] cmp_tag,
	input  logic              miss_valid,
	input  logic [`TAG_W-1:0] miss_tag,
	output rob_pkg::commit_t  commit,
	input  logic [`REG_W-1:0] qry_reg,
	output rob_pkg::status_t  qry_status
);

	rob_pkg::targets_t disp_tgt;
	rob_pkg::rob_entry_t [`ROB_ENTRIES-1:0] entries;
	logic [`ROB_ENTRIES-1:0] stomp;
	logic [`NREGS-1:0] livetarget;
	logic [`NREGS-1:0] livetarget2;
	logic [`ROB_ENTRIES-1:0][`NREGS-1:0] latest_id;
	logic [`ROB_ENTRIES-1:0][`NREGS-1:0] latest_id2;

	insn_decode u_decode (
		.insn (disp_insn),
		.tgt  (disp_tgt)
	);

	rob_buffer u_buffer (
		.clk        (clk),
		.reset      (reset),
		.disp_valid (disp_valid),
		.disp_tgt   (disp_tgt),
		.disp_tag   (disp_tag),
		.cmp_valid  (cmp_valid),
		.cmp_tag    (cmp_tag),
		.miss_valid (miss_valid),
		.miss_tag   (miss_tag),
		.entries    (entries),
		.stomp      (stomp),
		.commit     (commit),
		.credit     (credit)
	);

	// Evaluated every cycle, the status table only samples it on a miss
	rob_livetarget u_livetarget (
		.reb         (entries),
		.stomp       (stomp),
		.missid      (miss_tag),
		.livetarget  (livetarget),
		.livetarget2 (livetarget2),
		.latest_id   (latest_id),
		.latest_id2  (latest_id2)
	);

	reg_status u_status (
		.clk         (clk),
		.reset       (reset),
		.disp_valid  (disp_valid),
		.disp_tgt    (disp_tgt),
		.disp_tag    (disp_tag),
		.commit      (commit),
		.miss_valid  (miss_valid),
		.livetarget  (livetarget),
		.livetarget2 (livetarget2),
		.latest_id   (latest_id),
		.latest_id2  (latest_id2),
		.qry_reg     (qry_reg),
		.qry_status  (qry_status)
	);

endmodule

// File: hw/reg_status.sv
`timescale 1ns/1ps
`include "rob_params.svh"

// Per-register ready bit and producer tag
module reg_status (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               disp_valid,
	input  rob_pkg::targets_t                  disp_tgt,
	input  logic [`TAG_W-1:0]                  disp_tag,
	input  rob_pkg::commit_t                   commit,
	input  logic                               miss_valid,
	input  logic [`NREGS-1:0]                  livetarget,
	input  logic [`NREGS-1:0]                  livetarget2,
	input  logic [`ROB_ENTRIES-1:0][`NREGS-1:0] latest_id,
	input  logic [`ROB_ENTRIES-1:0][`NREGS-1:0] latest_id2,
	input  logic [`REG_W-1:0]                  qry_reg,
	output rob_pkg::status_t                   qry_status
);

	logic [`NREGS-1:0] ready_q;
	logic [`TAG_W-1:0] src_q [`NREGS];
	logic [`NREGS-1:0] live;
	logic [`NREGS-1:0] disp_hit;
	logic [`NREGS-1:0] cmp_hit;
	// Entries that claim to be the youngest writer of each register
	logic [`ROB_ENTRIES-1:0] owner [`NREGS];
	logic [`TAG_W-1:0] owner_tag [`NREGS];

	always_comb begin
		for (int r = 0; r < `NREGS; r++) begin
			live[r] = livetarget[r] | livetarget2[r];
			disp_hit[r] = disp_valid && r != 0
				&& (disp_tgt.tgt1 == `REG_W'(r) || disp_tgt.tgt2 == `REG_W'(r));
			// Only the entry that still owns the register may mark it ready
			cmp_hit[r] = commit.valid && r != 0
				&& (commit.tgt1 == `REG_W'(r) || commit.tgt2 == `REG_W'(r))
				&& src_q[r] == commit.tag;
			owner_tag[r] = '0;
			for (int n = 0; n < `ROB_ENTRIES; n++) begin
				owner[r][n] = latest_id[n][r] | latest_id2[n][r];
				if (owner[r][n])
					owner_tag[r] = `TAG_W'(n);
			end
		end
	end

	// ==================================================
	// Table update, rebuild beats dispatch beats commit
	// ==================================================

	always_ff @(posedge clk) begin
		if (reset) begin
			ready_q <= '1;
		end else begin
			for (int r = 0; r < `NREGS; r++) begin
				if (miss_valid)
					ready_q[r] <= !live[r];
				else if (disp_hit[r])
					ready_q[r] <= 1'b0;
				else if (cmp_hit[r])
					ready_q[r] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int r = 0; r < `NREGS; r++) begin
			if (miss_valid) begin
				if (live[r])
					src_q[r] <= owner_tag[r];
			end else if (disp_hit[r]) begin
				src_q[r] <= disp_tag;
			end
		end
	end

	// A ready register has no producer, so its tag reads as zero
	always_comb begin
		qry_status.ready = ready_q[qry_reg];
		qry_status.tag = ready_q[qry_reg] ? '0 : src_q[qry_reg];
	end

	// The live-target search must hand every live register to one entry
	for (genvar r = 1; r < `NREGS; r++) begin : g_owner_chk
		a_one_owner: assert property (@(posedge clk) disable iff (reset)
			miss_valid && live[r] |-> $onehot(owner[r]));
	end

endmodule

// File: hw/rob_buffer.sv
`timescale 1ns/1ps
`include "rob_params.svh"

// Eight-entry reorder buffer: allocation at the tail, completion by tag,
// in-order commit at the head and stomping of wrong-path entries
module rob_buffer (
	input  logic                                   clk,
	input  logic                                   reset,
	input  logic                                   disp_valid,
	input  rob_pkg::targets_t                      disp_tgt,
	output logic [`TAG_W-1:0]                      disp_tag,
	input  logic                                   cmp_valid,
	input  logic [`TAG_W-1:0]                      cmp_tag,
	input  logic                                   miss_valid,
	input  logic [`TAG_W-1:0]                      miss_tag,
	output rob_pkg::rob_entry_t [`ROB_ENTRIES-1:0] entries,
	output logic [`ROB_ENTRIES-1:0]                stomp,
	output rob_pkg::commit_t                       commit,
	output rob_pkg::credit_t                       credit
);

	logic [`TAG_W-1:0] head;
	logic [`TAG_W-1:0] tail;
	logic [`ROB_ENTRIES-1:0] valid_q;
	logic [`ROB_ENTRIES-1:0] done_q;
	logic [`REG_W-1:0] tgt1_q [`ROB_ENTRIES];
	logic [`REG_W-1:0] tgt2_q [`ROB_ENTRIES];
	// Distance from the head, larger means younger
	logic [`TAG_W-1:0] age [`ROB_ENTRIES];
	logic retire;
	logic [`CREDIT_W-1:0] freed;

	// ==================================================
	// Age, stomp and commit
	// ==================================================

	always_comb begin
		for (int n = 0; n < `ROB_ENTRIES; n++)
			age[n] = `TAG_W'(n) - head;
	end

	// Everything younger than the mispredicted branch is on the wrong path
	always_comb begin
		for (int n = 0; n < `ROB_ENTRIES; n++)
			stomp[n] = miss_valid && valid_q[n] && (age[n] > age[miss_tag]);
	end

	assign retire = valid_q[head] && done_q[head];
	assign disp_tag = tail;

	always_comb begin
		commit.valid = retire;
		commit.tag = head;
		commit.tgt1 = tgt1_q[head];
		commit.tgt2 = tgt2_q[head];
	end

	// The head that retires this cycle is shown as already gone, so a
	// recovery in the same cycle does not count its targets as live
	always_comb begin
		for (int n = 0; n < `ROB_ENTRIES; n++) begin
			entries[n].valid = valid_q[n] && !(retire && head == `TAG_W'(n));
			entries[n].done = done_q[n];
			entries[n].tgt1 = tgt1_q[n];
			entries[n].tgt2 = tgt2_q[n];
			entries[n].age = age[n];
		end
	end

	// One credit per retired entry plus one per stomped entry
	always_comb begin
		freed = `CREDIT_W'(retire);
		for (int n = 0; n < `ROB_ENTRIES; n++)
			freed = freed + `CREDIT_W'(stomp[n]);
	end
	assign credit.count = freed;

	// ==================================================
	// State update
	// ==================================================

	always_ff @(posedge clk) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
			valid_q <= '0;
			done_q <= '0;
		end else begin
			if (retire)
				head <= head + 1'b1;
			for (int n = 0; n < `ROB_ENTRIES; n++) begin
				if (stomp[n] || (retire && head == `TAG_W'(n)))
					valid_q[n] <= 1'b0;
			end
			if (cmp_valid)
				done_q[cmp_tag] <= 1'b1;
			if (disp_valid) begin
				valid_q[tail] <= 1'b1;
				done_q[tail] <= 1'b0;
				tail <= tail + 1'b1;
			end
			// Allocation resumes right behind the branch
			if (miss_valid)
				tail <= miss_tag + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (disp_valid) begin
			tgt1_q[tail] <= disp_tgt.tgt1;
			tgt2_q[tail] <= disp_tgt.tgt2;
		end
	end

	// Credit accounting at the sender must keep the tail slot free
	a_disp_free: assert property (@(posedge clk) disable iff (reset)
		disp_valid |-> !valid_q[tail]);
	a_cmp_live: assert property (@(posedge clk) disable iff (reset)
		cmp_valid |-> valid_q[cmp_tag] && !stomp[cmp_tag]);
	a_no_disp_miss: assert property (@(posedge clk) disable iff (reset)
		!(disp_valid && miss_valid));

endmodule

// File: hw/rob_livetarget.sv
`timescale 1ns/1ps
`include "rob_params.svh"

// Finds the registers still targeted by surviving entries after a stomp
// and, for each one, the youngest surviving entry that writes it
module rob_livetarget (
	input  rob_pkg::rob_entry_t [`ROB_ENTRIES-1:0] reb,
	input  logic [`ROB_ENTRIES-1:0]                 stomp,
	input  logic [`TAG_W-1:0]                       missid,
	output logic [`NREGS-1:0]                       livetarget,
	output logic [`NREGS-1:0]                       livetarget2,
	output logic [`ROB_ENTRIES-1:0][`NREGS-1:0]     latest_id,
	output logic [`ROB_ENTRIES-1:0][`NREGS-1:0]     latest_id2
);

	// One-hot target masks per entry, zero for dead or stomped entries
	logic [`ROB_ENTRIES-1:0][`NREGS-1:0] mask1;
	logic [`ROB_ENTRIES-1:0][`NREGS-1:0] mask2;
	// Targets written by entries younger than this one, up to the miss entry
	logic [`ROB_ENTRIES-1:0][`NREGS-1:0] younger;

	// ==================================================
	// Per-entry target masks
	// ==================================================

	always_comb begin
		for (int n = 0; n < `ROB_ENTRIES; n++) begin
			mask1[n] = '0;
			mask2[n] = '0;
			if (reb[n].valid && !stomp[n]) begin
				mask1[n] = `NREGS'(1) << reb[n].tgt1;
				mask2[n] = `NREGS'(1) << reb[n].tgt2;
			end
			// Register zero is never tracked
			mask1[n][0] = 1'b0;
			mask2[n][0] = 1'b0;
		end
	end

	always_comb begin
		livetarget = '0;
		livetarget2 = '0;
		for (int n = 0; n < `ROB_ENTRIES; n++) begin
			livetarget = livetarget | mask1[n];
			livetarget2 = livetarget2 | mask2[n];
		end
	end

	// ==================================================
	// Youngest writer selection
	// ==================================================

	// Both target slots feed the younger set so that a register written
	// through slot one of one entry and slot two of another still gets
	// exactly one owner
	always_comb begin
		for (int n = 0; n < `ROB_ENTRIES; n++) begin
			younger[n] = '0;
			for (int k = 0; k < `ROB_ENTRIES; k++) begin
				if (reb[k].age > reb[n].age && reb[k].age <= reb[missid].age)
					younger[n] = younger[n] | mask1[k] | mask2[k];
			end
		end
	end

	// An entry owns its target only when nothing younger but still alive
	// writes that same register
	always_comb begin
		for (int n = 0; n < `ROB_ENTRIES; n++) begin
			latest_id[n] = '0;
			latest_id2[n] = '0;
			if (missid == `TAG_W'(n) || (mask1[n] & younger[n]) == '0)
				latest_id[n] = mask1[n];
			if (missid == `TAG_W'(n) || (mask2[n] & younger[n]) == '0)
				latest_id2[n] = mask2[n];
		end
	end

endmodule

// File: hw/insn_decode.sv
`timescale 1ns/1ps

// Extracts the destination registers of a dispatched word
module insn_decode (
	input  rob_pkg::insn_u    insn,
	output rob_pkg::targets_t tgt
);

	// The kind bit sits at the top of both formats so either view can test it
	// A branch writes no register, its offset is resolved elsewhere
	always_comb begin
		if (insn.b.kind) begin
			tgt.tgt1 = '0;
			tgt.tgt2 = '0;
			tgt.is_branch = 1'b1;
		end else begin
			// Register zero in a target field simply means no destination
			tgt.tgt1 = insn.r.tgt1;
			tgt.tgt2 = insn.r.tgt2;
			tgt.is_branch = 1'b0;
		end
	end

endmodule

// File: hw/rob_pkg.sv
`include "rob_params.svh"

package rob_pkg;

	// Register format, kind bit clear, two destination registers
	typedef struct packed {
		logic kind;
		logic [`REG_W-1:0] tgt1;
		logic [`REG_W-1:0] tgt2;
		logic [`INSN_W-2*`REG_W-2:0] spare;
	} insn_reg_t;

	// Branch format, kind bit set, the offset is carried but not used here
	typedef struct packed {
		logic kind;
		logic [`INSN_W-2:0] offset;
	} insn_br_t;

	// One dispatched word seen through either format
	typedef union packed {
		insn_reg_t r;
		insn_br_t b;
	} insn_u;

	// Decoded destinations of one instruction
	typedef struct packed {
		logic [`REG_W-1:0] tgt1;
		logic [`REG_W-1:0] tgt2;
		logic is_branch;
	} targets_t;

	// Buffer entry as seen outside the buffer, age 0 is the head
	typedef struct packed {
		logic valid;
		logic done;
		logic [`REG_W-1:0] tgt1;
		logic [`REG_W-1:0] tgt2;
		logic [`TAG_W-1:0] age;
	} rob_entry_t;

	// Entries released back to the sender this cycle
	typedef struct packed {
		logic [`CREDIT_W-1:0] count;
	} credit_t;

	typedef struct packed {
		logic valid;
		logic [`TAG_W-1:0] tag;
		logic [`REG_W-1:0] tgt1;
		logic [`REG_W-1:0] tgt2;
	} commit_t;

	// Register status, tag is the producing entry while not ready
	typedef struct packed {
		logic ready;
		logic [`TAG_W-1:0] tag;
	} status_t;

endpackage

// File: hw/rob_params.svh
`ifndef ROB_PARAMS_SVH
`define ROB_PARAMS_SVH

// ==================================================
// Reorder buffer sizing
// ==================================================

// Number of in-flight instructions the buffer can hold
`define ROB_ENTRIES 8
// Tag width, enough to name every buffer entry
`define TAG_W 3
// Credit counter width, holds up to ROB_ENTRIES freed slots in one cycle
`define CREDIT_W 4

// ==================================================
// Architectural registers and instruction word
// ==================================================

`define NREGS 32
`define REG_W 5
`define INSN_W 16

`endif
